//--- project.f
src/ddr4_pkg.sv
src/bank_state_tracker.sv
src/read_return_queue.sv
src/cmd_scheduler.sv
src/ddr4_ctrl_top.sv
sim/tb_clock_gen.sv
sim/ddr4_ctrl_assertions.sv
sim/tb_ddr4_ctrl.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_ddr4_ctrl \
    -Mdir obj_dir -o Vtb_ddr4_ctrl \
    && ./obj_dir/Vtb_ddr4_ctrl | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/tb_ddr4_ctrl.sv
// DDR4 controller testbench
module tb_ddr4_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import ddr4_pkg::*;

    localparam int NUM_REQ        = 43;  // directed plus random requests
    localparam int TIMEOUT_CYCLES = NUM_REQ * (PRECHARGE_LATENCY + ACTIVATION_LATENCY
                                    + CAS_LATENCY + 4) + 200;

    typedef struct packed {
        dram_cmd_t   cmd;
        logic [31:0] cyc;   // edge at which the command is seen on the pins
    } exp_cmd_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [31:0]          cyc;
    } exp_rsp_t;

    logic                 clk_in;
    logic                 rst_N_in;
    logic                 req_valid;
    host_req_t            req;
    logic                 busy;
    logic                 rsp_valid;
    logic [DATA_BITS-1:0] rsp_data;
    dram_cmd_t            dram_cmd;
    logic [DATA_BITS-1:0] dq_out;
    logic                 dq_oe;
    logic [DATA_BITS-1:0] dq_in = '0;

    int    cyc = 0;        // rising edges since time zero
    int    errors = 0;
    int    in_flight = 0;
    int    peak_in_flight = 0;
    string test_name = "reset";

    // reference model state
    exp_cmd_t             exp_cmds [$];
    exp_rsp_t             exp_rsps [$];
    logic                 ref_open [NUM_BANKS];
    logic [ROW_BITS-1:0]  ref_row  [NUM_BANKS];
    logic [DATA_BITS-1:0] shadow   [logic [PADDR_BITS-1:0]];  // every write by host address

    // dimm model state
    logic [DATA_BITS-1:0] dimm_mem     [2**PADDR_BITS];
    bit                   dimm_written [2**PADDR_BITS];
    logic [ROW_BITS-1:0]  dimm_row     [NUM_BANKS];
    logic [DATA_BITS-1:0] sched_data   [64];  // dq_in schedule with slot = cycle mod 64
    bit                   sched_valid  [64];

    tb_clock_gen u_clk (.clk_in(clk_in), .rst_N_in(rst_N_in));

    ddr4_ctrl_top dut (
        .clk_in    (clk_in),
        .rst_N_in  (rst_N_in),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .dram_cmd  (dram_cmd),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in)
    );

    // word returned for never-written locations keyed by {bank, row, col}
    function automatic logic [DATA_BITS-1:0] fill_word(input logic [PADDR_BITS-1:0] key);
        return (64'(key) * 64'h9E37_79B9_7F4A_7C15) ^ 64'hA5A5_0000_0000_5A5A;
    endfunction

    function automatic dram_cmd_t make_cmd(input dram_cmd_e kind,
                                           input logic [BANK_BITS-1:0] bank,
                                           input logic [DRAM_ADDR_BITS-1:0] addr);
        dram_cmd_t c;
        c.cmd  = kind;
        c.bg   = bank[BANK_BITS-1:BA_BITS];
        c.ba   = bank[BA_BITS-1:0];
        c.addr = addr;
        return c;
    endfunction

    // reference queues the expected command sequence and read data for one request
    function automatic void predict_request(input host_req_t r, input int base);
        logic [ROW_BITS-1:0]  row;
        logic [BANK_BITS-1:0] bank;
        logic [COL_BITS-1:0]  col;
        int                   at;
        exp_cmd_t             e;
        exp_rsp_t             x;
        {row, bank, col} = r.addr;
        at = base + 1;  // first command one cycle after accept
        if (!(ref_open[bank] && (ref_row[bank] == row))) begin
            if (ref_open[bank]) begin
                e.cmd = make_cmd(PRE, bank, '0);
                e.cyc = 32'(at);
                exp_cmds.push_back(e);
                at += PRECHARGE_LATENCY;
            end
            e.cmd = make_cmd(ACT, bank, DRAM_ADDR_BITS'(row));
            e.cyc = 32'(at);
            exp_cmds.push_back(e);
            at += ACTIVATION_LATENCY;
            ref_open[bank] = 1'b1;
            ref_row[bank]  = row;
        end
        e.cmd = make_cmd(r.write ? WR : RD, bank, DRAM_ADDR_BITS'(col));
        e.cyc = 32'(at);
        exp_cmds.push_back(e);
        if (r.write) begin
            shadow[r.addr] = r.wdata;
        end else begin
            x.data = shadow.exists(r.addr) ? shadow[r.addr] : fill_word({bank, row, col});
            x.cyc  = 32'(at + CAS_LATENCY + 1);
            exp_rsps.push_back(x);
        end
    endfunction

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // cycle count and run limit
    always @(posedge clk_in) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout reached after %0d cycles, run aborted", cyc);
            $display("TB FAILED");
            $finish;
        end
    end

    // dimm stores writes and plays read data back CAS_LATENCY after RD
    always @(posedge clk_in) begin : dimm_model
        logic [BANK_BITS-1:0]  b;
        logic [PADDR_BITS-1:0] idx;
        int                    slot;
        b    = {dram_cmd.bg, dram_cmd.ba};
        idx  = {b, dimm_row[b], dram_cmd.addr[COL_BITS-1:0]};
        slot = cyc % 64;
        dq_in <= sched_valid[slot] ? sched_data[slot] : '0;
        sched_valid[slot] = 1'b0;
        case (dram_cmd.cmd)
            ACT: dimm_row[b] = dram_cmd.addr[ROW_BITS-1:0];
            WR: begin
                if (dq_oe) begin
                    dimm_mem[idx]     = dq_out;
                    dimm_written[idx] = 1'b1;
                end
            end
            RD: begin
                slot = (cyc + CAS_LATENCY - 1) % 64;  // seen one edge late already
                sched_data[slot]  = dimm_written[idx] ? dimm_mem[idx] : fill_word(idx);
                sched_valid[slot] = 1'b1;
            end
            default: ;
        endcase
    end

    // compare pins and responses against the reference queues
    always @(posedge clk_in) begin : compare
        exp_cmd_t e;
        exp_rsp_t x;
        int       pin_cyc;
        pin_cyc = cyc - 1;  // edge that registered what the pins show now
        if (!rst_N_in) begin
            if (dram_cmd.cmd != NOP) begin
                if (exp_cmds.size() == 0) begin
                    errors++;
                    $display("%s: command %h at cycle %0d that no request called for",
                             test_name, dram_cmd, pin_cyc);
                end else begin
                    e = exp_cmds.pop_front();
                    check("command", 64'(e.cmd), 64'(dram_cmd));
                    check("command cycle", 64'(e.cyc), 64'(pin_cyc));
                end
            end else if ((exp_cmds.size() != 0) && (pin_cyc > int'(exp_cmds[0].cyc))) begin
                errors++;
                $display("%s: expected command %h never came at cycle %0d",
                         test_name, exp_cmds[0].cmd, exp_cmds[0].cyc);
                void'(exp_cmds.pop_front());
            end
            if (dram_cmd.cmd == RD) begin
                in_flight++;
            end
            if (in_flight > peak_in_flight) begin
                peak_in_flight = in_flight;
            end
            if (rsp_valid) begin
                in_flight--;
                if (exp_rsps.size() == 0) begin
                    errors++;
                    $display("%s: response at cycle %0d with no read outstanding",
                             test_name, pin_cyc);
                end else begin
                    x = exp_rsps.pop_front();
                    check("read data", x.data, rsp_data);
                    check("response cycle", 64'(x.cyc), 64'(pin_cyc));
                end
            end
        end
    end

    // one request entered on an edge where busy was low
    task automatic send_request(input logic wr, input logic [PADDR_BITS-1:0] addr,
                                input logic [DATA_BITS-1:0] data);
        host_req_t r;
        r.write = wr;
        r.addr  = addr;
        r.wdata = data;
        predict_request(r, cyc + 1);  // accepted on the next edge
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk_in);
        req_valid <= 1'b0;
        @(posedge clk_in);
        while (busy) @(posedge clk_in);
    endtask

    task automatic wait_drained();
        while ((exp_cmds.size() != 0) || (exp_rsps.size() != 0)) @(posedge clk_in);
        repeat (2) @(posedge clk_in);
    endtask

    function automatic logic [PADDR_BITS-1:0] random_addr();
        logic [ROW_BITS-1:0] pool [3];
        pool[0] = 8'h11;
        pool[1] = 8'h22;
        pool[2] = 8'h33;  // few rows, so hits and conflicts both happen
        return {pool[$urandom_range(2, 0)], BANK_BITS'($urandom_range(3, 0)),
                COL_BITS'($urandom_range(15, 0))};
    endfunction

    initial begin
        req_valid = 1'b0;
        req       = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            ref_open[b] = 1'b0;
            ref_row[b]  = '0;
        end
        void'($urandom(32'h4d05fd67));
        @(negedge rst_N_in);
        @(posedge clk_in);
        check("dram_cmd", 64'(NOP), 64'(dram_cmd));
        check("dq_oe", 64'(0), 64'(dq_oe));
        check("busy", 64'(0), 64'(busy));
        check("rsp_valid", 64'(0), 64'(rsp_valid));

        test_name = "closed_bank";  // row 5, bank 2, col 3
        send_request(1'b1, {8'h05, 3'd2, 4'd3}, 64'hDEAD_BEEF_0123_4567);
        test_name = "write_read";   // same row now open so a hit
        send_request(1'b0, {8'h05, 3'd2, 4'd3}, '0);
        wait_drained();
        test_name = "row_conflict";
        send_request(1'b0, {8'h09, 3'd2, 4'd1}, '0);
        wait_drained();

        test_name = "random_mix";
        for (int i = 0; i < 16; i++) begin
            send_request($urandom_range(2, 0) == 0, random_addr(), {$urandom, $urandom});
        end
        wait_drained();
        test_name = "random_reads";
        peak_in_flight = 0;
        for (int i = 0; i < 24; i++) begin
            send_request(1'b0, random_addr(), '0);
        end
        wait_drained();
        check("several reads in flight", 64'(1), 64'(peak_in_flight >= 2));

        $display("%0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim/ddr4_ctrl_assertions.sv
// DDR4 controller protocol assertions
module ddr4_ctrl_assertions (
    input logic                clk_in,
    input logic                rst_N_in,
    input ddr4_pkg::dram_cmd_t dram_cmd,
    input logic                dq_oe,
    input logic                busy,
    input logic                rsp_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import ddr4_pkg::*;

    int unsigned reads_open;  // RD seen on the pins, response not yet back

    always_ff @(posedge clk_in or posedge rst_N_in) begin
        if (rst_N_in) begin
            reads_open <= 0;
        end else if ((dram_cmd.cmd == RD) && !rsp_valid) begin
            reads_open <= reads_open + 1;
        end else if ((dram_cmd.cmd != RD) && rsp_valid && (reads_open != 0)) begin
            reads_open <= reads_open - 1;
        end
    end

    // pins stay quiet while reset is held
    a_nop_in_reset: assert property (@(posedge clk_in) rst_N_in |-> dram_cmd.cmd == NOP)
        else $error("command on the dimm pins during reset");

    a_oe_with_wr: assert property (@(posedge clk_in) disable iff (rst_N_in)
        dq_oe |-> dram_cmd.cmd == WR)
        else $error("dq driven without a WR command");

    // busy drops only on the edge the access goes out
    a_busy_fall: assert property (@(posedge clk_in) disable iff (rst_N_in)
        $fell(busy) |-> (dram_cmd.cmd == RD) || (dram_cmd.cmd == WR))
        else $error("busy fell without an RD or WR on the pins");

    a_rsp_has_rd: assert property (@(posedge clk_in) disable iff (rst_N_in)
        rsp_valid |-> reads_open != 0)
        else $error("response returned with no read outstanding");

endmodule

bind ddr4_ctrl_top ddr4_ctrl_assertions u_assertions (.*);

//--- sim/tb_clock_gen.sv
// Testbench clock and reset
module tb_clock_gen (
    output logic clk_in,
    output logic rst_N_in
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;  // 8 ns period
    end

    // reset held for four rising edges, active high
    initial begin
        rst_N_in = 1'b1;
        repeat (4) @(posedge clk_in);
        rst_N_in <= 1'b0;
    end

endmodule

//--- src/ddr4_ctrl_top.sv
// DDR4 controller top level
module ddr4_ctrl_top (
    input  logic                             clk_in,
    input  logic                             rst_N_in,
    // host side
    input  logic                             req_valid,
    input  ddr4_pkg::host_req_t              req,
    output logic                             busy,
    output logic                             rsp_valid,
    output logic [ddr4_pkg::DATA_BITS-1:0]   rsp_data,
    // dimm side, dq split into in, out and enable
    output ddr4_pkg::dram_cmd_t              dram_cmd,
    output logic [ddr4_pkg::DATA_BITS-1:0]   dq_out,
    output logic                             dq_oe,
    input  logic [ddr4_pkg::DATA_BITS-1:0]   dq_in
);
    import ddr4_pkg::*;

    logic [BANK_BITS-1:0] query_bank;
    logic [ROW_BITS-1:0]  query_row;
    bank_status_t         status;      // tracker -> scheduler, same cycle
    dram_cmd_t            issue_cmd;   // scheduler -> tracker and return queue
    logic                 queue_full;

    // picks one command per cycle from bank status and queue space
    cmd_scheduler u_sched (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .req_valid  (req_valid),
        .req        (req),
        .status     (status),
        .queue_full (queue_full),
        .busy       (busy),
        .query_bank (query_bank),
        .query_row  (query_row),
        .issue_cmd  (issue_cmd),
        .dram_cmd   (dram_cmd),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe)
    );

    // tracker follows ACT/PRE while the queue follows RD, both off the same command
    bank_state_tracker u_tracker (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .issue_cmd  (issue_cmd),
        .query_bank (query_bank),
        .query_row  (query_row),
        .status     (status)
    );

    read_return_queue u_rrq (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .issue_cmd  (issue_cmd),
        .dq_in      (dq_in),
        .full       (queue_full),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

endmodule

//--- src/cmd_scheduler.sv
// DDR4 command scheduler
module cmd_scheduler (
    input  logic                             clk_in,
    input  logic                             rst_N_in,
    input  logic                             req_valid,   // host strobe, taken while not busy
    input  ddr4_pkg::host_req_t              req,
    input  ddr4_pkg::bank_status_t           status,      // tracker view of the pending bank
    input  logic                             queue_full,  // return queue cannot take a read
    output logic                             busy,
    output logic [ddr4_pkg::BANK_BITS-1:0]   query_bank,
    output logic [ddr4_pkg::ROW_BITS-1:0]    query_row,
    output ddr4_pkg::dram_cmd_t              issue_cmd,   // command chosen this cycle
    output ddr4_pkg::dram_cmd_t              dram_cmd,    // registered onto the dimm pins
    output logic [ddr4_pkg::DATA_BITS-1:0]   dq_out,
    output logic                             dq_oe
);
    import ddr4_pkg::*;

    logic                pend_valid;  // a request is waiting for its access
    host_req_t           pend_req;
    dram_cmd_e           next_cmd;
    logic                accept;
    logic                access_issued;

    // decoded fields of the pending address
    logic [ROW_BITS-1:0] row;
    logic [BG_BITS-1:0]  bg;
    logic [BA_BITS-1:0]  ba;
    logic [COL_BITS-1:0] col;

    assign accept = req_valid && !pend_valid;
    assign {row, bg, ba, col} = pend_req.addr;  // row in the top bits, col at the bottom

    assign query_bank = {bg, ba};
    assign query_row  = row;

    // held from the accept edge until the edge the access goes out,
    // and therefore also through any wait on a full return queue
    assign busy = pend_valid;

    // command choice for the pending request
    always_comb begin
        next_cmd = NOP;
        if (pend_valid && !status.blocked) begin
            if (status.hit) begin
                if (pend_req.write) begin
                    next_cmd = WR;
                end else if (!queue_full) begin
                    next_cmd = RD;  // only if the response has a slot to land in
                end
            end else if (status.open) begin
                next_cmd = PRE;  // wrong row open, close it first
            end else begin
                next_cmd = ACT;
            end
        end
    end

    assign access_issued = (next_cmd == RD) || (next_cmd == WR);

    // pack the command, the address pins follow the command type
    always_comb begin
        issue_cmd     = '0;
        issue_cmd.cmd = next_cmd;
        case (next_cmd)
            ACT: begin
                issue_cmd.addr = DRAM_ADDR_BITS'(row);  // row in the low bits
            end
            RD, WR: begin
                // column in the low bits, A10 stays 0 so no auto-precharge
                issue_cmd.addr = DRAM_ADDR_BITS'(col);
            end
            default: ;  // PRE with A10 low = single bank, NOP all zero
        endcase
        if (next_cmd != NOP) begin
            issue_cmd.bg = bg;
            issue_cmd.ba = ba;
        end
    end

    always_ff @(posedge clk_in or posedge rst_N_in) begin
        if (rst_N_in) begin
            pend_valid <= 1'b0;
            dram_cmd   <= '0;     // NOP, cs deasserted
            dq_oe      <= 1'b0;
        end else begin
            if (access_issued) begin
                pend_valid <= 1'b0;  // request done once RD/WR is out
            end else if (accept) begin
                pend_valid <= 1'b1;
            end
            dram_cmd <= issue_cmd;
            dq_oe    <= (next_cmd == WR);  // drive dq together with WR
        end
    end

    // request and write data registers
    always_ff @(posedge clk_in) begin
        if (accept) begin
            pend_req <= req;
        end
        if (next_cmd == WR) begin
            dq_out <= pend_req.wdata;
        end
    end

endmodule

//--- src/read_return_queue.sv
// Read return queue
module read_return_queue (
    input  logic                             clk_in,
    input  logic                             rst_N_in,
    input  ddr4_pkg::dram_cmd_t              issue_cmd,  // RD pushes a due stamp
    input  logic [ddr4_pkg::DATA_BITS-1:0]   dq_in,      // data from the dimm
    output logic                             full,       // no room for another read
    output logic                             rsp_valid,  // one-cycle pulse per read
    output logic [ddr4_pkg::DATA_BITS-1:0]   rsp_data
);
    import ddr4_pkg::*;

    logic [STAMP_BITS-1:0]   stamp_q;                // free-running cycle count
    logic [STAMP_BITS-1:0]   due_mem [RET_DEPTH];    // capture cycle per read, in RD order
    logic [RET_PTR_BITS-1:0] wr_ptr;
    logic [RET_PTR_BITS-1:0] rd_ptr;
    logic [RET_PTR_BITS:0]   count_q;                // one extra bit to tell full from empty
    logic                    push;
    logic                    pop;

    assign push = (issue_cmd.cmd == RD);
    assign pop  = (count_q != '0) && (due_mem[rd_ptr] == stamp_q);  // head is due now
    assign full = (count_q == (RET_PTR_BITS + 1)'(RET_DEPTH));

    always_ff @(posedge clk_in or posedge rst_N_in) begin
        if (rst_N_in) begin
            stamp_q   <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count_q   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            stamp_q <= stamp_q + 1'b1;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps by itself
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;  // both or neither, count holds
            endcase
            rsp_valid <= pop;
        end
    end

    // issue_cmd is one cycle ahead of the pins, and dq_in is valid during the
    // cycle CAS_LATENCY after RD, so it is captured at the edge closing that cycle
    always_ff @(posedge clk_in) begin
        if (push) begin
            due_mem[wr_ptr] <= stamp_q + STAMP_BITS'(CAS_LATENCY + 1);
        end
        if (pop) begin
            rsp_data <= dq_in;
        end
    end

endmodule

//--- src/bank_state_tracker.sv
// Per-bank row state
module bank_state_tracker (
    input  logic                             clk_in,
    input  logic                             rst_N_in,
    input  ddr4_pkg::dram_cmd_t              issue_cmd,   // command going out this cycle
    input  logic [ddr4_pkg::BANK_BITS-1:0]   query_bank,  // {bg, ba} of the pending request
    input  logic [ddr4_pkg::ROW_BITS-1:0]    query_row,
    output ddr4_pkg::bank_status_t           status
);
    import ddr4_pkg::*;

    logic [NUM_BANKS-1:0]  open_q;              // row open per bank
    logic [ROW_BITS-1:0]   row_q   [NUM_BANKS]; // which row, valid only while open
    logic [TIMER_BITS-1:0] timer_q [NUM_BANKS]; // settling down-counter
    logic [BANK_BITS-1:0]  issue_bank;

    assign issue_bank = {issue_cmd.bg, issue_cmd.ba};

    // counters are loaded with latency - 1 at the edge that puts the command
    // on the pins, the bank then reads as blocked for latency - 1 cycles and
    // the next command for it lands exactly latency cycles after this one
    always_ff @(posedge clk_in or posedge rst_N_in) begin
        if (rst_N_in) begin
            open_q <= '0;  // all banks precharged after reset
            for (int b = 0; b < NUM_BANKS; b++) begin
                timer_q[b] <= '0;
            end
        end else begin
            // every bank settles on its own
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (timer_q[b] != '0) begin
                    timer_q[b] <= timer_q[b] - 1'b1;
                end
            end
            case (issue_cmd.cmd)
                ACT: begin
                    open_q[issue_bank]  <= 1'b1;
                    timer_q[issue_bank] <= TIMER_BITS'(ACTIVATION_LATENCY - 1);
                end
                PRE: begin
                    open_q[issue_bank]  <= 1'b0;  // row buffer written back
                    timer_q[issue_bank] <= TIMER_BITS'(PRECHARGE_LATENCY - 1);
                end
                default: ;  // RD/WR leave the row open, NOP does nothing
            endcase
        end
    end

    // row address comes from the low bits of the ACT address
    always_ff @(posedge clk_in) begin
        if (issue_cmd.cmd == ACT) begin
            row_q[issue_bank] <= issue_cmd.addr[ROW_BITS-1:0];
        end
    end

    // lookup of the queried bank, purely combinational
    always_comb begin
        status.open    = open_q[query_bank];
        status.hit     = open_q[query_bank] && (row_q[query_bank] == query_row);
        status.blocked = (timer_q[query_bank] != '0);
    end

endmodule

//--- src/ddr4_pkg.sv
// DDR4 controller shared definitions
package ddr4_pkg;

    // dram timing, all in controller clock cycles
    localparam int CAS_LATENCY        = 22;  // RD on the pins to data valid on dq_in
    localparam int ACTIVATION_LATENCY = 8;   // bank unusable after ACT
    localparam int PRECHARGE_LATENCY  = 5;   // bank unusable after PRE

    // address geometry
    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 4;
    localparam int BG_BITS   = 1;
    localparam int BA_BITS   = 2;
    localparam int BANK_BITS = BG_BITS + BA_BITS;                // flat bank index {bg, ba}
    localparam int NUM_BANKS = (1 << BG_BITS) * (1 << BA_BITS);  // 2 groups x 4 banks

    // host address is {row, bg, ba, col}, 15 bits
    localparam int PADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS;

    localparam int DATA_BITS      = 64;  // same width on host and dimm side
    localparam int DRAM_ADDR_BITS = 17;  // A16..A0 on the dimm

    // reads in flight
    localparam int RET_DEPTH    = 8;
    localparam int RET_PTR_BITS = $clog2(RET_DEPTH);
    localparam int STAMP_BITS   = 16;  // free-running cycle stamp, wraps

    // settling counter has to hold the larger of the two latencies
    localparam int TIMER_BITS = $clog2(
        (ACTIVATION_LATENCY > PRECHARGE_LATENCY ? ACTIVATION_LATENCY : PRECHARGE_LATENCY) + 1);

    // commands put on the dimm, NOP stands for cs deasserted
    typedef enum logic [2:0] {
        NOP = 3'd0,
        ACT = 3'd1,
        PRE = 3'd2,
        RD  = 3'd3,
        WR  = 3'd4
    } dram_cmd_e;

    // one dimm command, 23 bits
    typedef struct packed {
        dram_cmd_e                 cmd;
        logic [BG_BITS-1:0]        bg;
        logic [BA_BITS-1:0]        ba;
        logic [DRAM_ADDR_BITS-1:0] addr;  // row for ACT, col for RD/WR, zero for PRE
    } dram_cmd_t;

    // host request, 80 bits
    typedef struct packed {
        logic                  write;  // 1 = write, 0 = read
        logic [PADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]  wdata;
    } host_req_t;

    // state of the bank the scheduler is looking at
    typedef struct packed {
        logic open;     // a row is open
        logic hit;      // the open row is the requested one
        logic blocked;  // still settling from ACT or PRE
    } bank_status_t;

endpackage
